//--- Makefile
# Verilator build and run of the ext_dev testbench
# Pass or fail comes from a search for the pass message in the log

VERILATOR ?= verilator
TOP       ?= tb_ext_dev_top
FILELIST  ?= ext_dev.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
PASS_MSG  ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/ext_dev_params.svh
// Shared sizes for the ext_dev blocks
// The slow memory index width must match its word count (2**MEM_AW words)

`ifndef EXT_DEV_PARAMS_SVH
`define EXT_DEV_PARAMS_SVH

// Bus data width in bits
`define EXT_DEV_DATA_W 32

// Slow memory depth and word index width
`define EXT_DEV_MEM_WORDS 128
`define EXT_DEV_MEM_AW 7

// Rising edges per gpio_o toggle
`define EXT_DEV_CNT_MAX 8

// Copy length in words
`define EXT_DEV_LEN_W 8

`endif

//--- common/ext_dev_pkg.sv
// Bus types and register map of the ext_dev blocks
// Byte enables are 4 bits, so the data width stays at 32

`include "ext_dev_params.svh"

package ext_dev_pkg;

  // OBI request from a master
  typedef struct packed {
    logic                       req;
    logic                       we;
    logic [3:0]                 be;
    logic [31:0]                addr;
    logic [`EXT_DEV_DATA_W-1:0] wdata;
  } obi_req_t;

  // OBI slave answer where rvalid also closes a write
  typedef struct packed {
    logic                       gnt;
    logic                       rvalid;
    logic [`EXT_DEV_DATA_W-1:0] rdata;
  } obi_resp_t;

  // Register bus request with valid as a single strobe
  typedef struct packed {
    logic                       valid;
    logic                       write;
    logic [31:0]                addr;
    logic [`EXT_DEV_DATA_W-1:0] wdata;
    logic [3:0]                 wstrb;
  } reg_req_t;

  typedef struct packed {
    logic                       ready;
    logic                       error;
    logic [`EXT_DEV_DATA_W-1:0] rdata;
  } reg_rsp_t;

  // Memcopy register offsets
  localparam logic [31:0] REG_SRC  = 32'h0;
  localparam logic [31:0] REG_DST  = 32'h4;
  localparam logic [31:0] REG_LEN  = 32'h8;
  localparam logic [31:0] REG_CTRL = 32'hC;

endpackage

//--- ext_dev.f
+incdir+common
common/ext_dev_pkg.sv
slow_memory/slow_memory.sv
memcopy/memcopy_regs.sv
memcopy/memcopy_engine.sv
logic/obi_arbiter.sv
logic/gpio_cnt.sv
logic/ext_dev_top.sv
testbench/tb_ext_dev_top.sv

//--- logic/ext_dev_top.sv
// External device corner with memcopy, slow memory and GPIO counter
// Host and copy engine share the slow memory and the host has priority

`timescale 1ns/1ns

`include "ext_dev_params.svh"

module ext_dev_top
  import ext_dev_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  reg_req_t  reg_req_i,
  output reg_rsp_t  reg_rsp_o,
  input  obi_req_t  host_req_i,
  output obi_resp_t host_resp_o,
  input  logic      gpio_i,
  output logic      gpio_o,
  output logic      memcopy_intr_o
);

  logic [31:0]               src;
  logic [31:0]               dst;
  logic [`EXT_DEV_LEN_W-1:0] len;
  logic                      start;
  logic                      busy;
  logic                      done;
  obi_req_t                  eng_req;
  obi_resp_t                 eng_resp;
  obi_req_t                  mem_req;
  obi_resp_t                 mem_resp;

  memcopy_regs memcopy_regs_i (
    .clk_i,
    .arst_n_i,
    .reg_req_i,
    .reg_rsp_o,
    .busy_i (busy),
    .src_o  (src),
    .dst_o  (dst),
    .len_o  (len),
    .start_o(start)
  );

  memcopy_engine memcopy_engine_i (
    .clk_i,
    .arst_n_i,
    .src_i     (src),
    .dst_i     (dst),
    .len_i     (len),
    .start_i   (start),
    .busy_o    (busy),
    .obi_req_o (eng_req),
    .obi_resp_i(eng_resp),
    .done_o    (done)
  );

  // Host on m0, copy engine on m1
  obi_arbiter obi_arbiter_i (
    .clk_i,
    .arst_n_i,
    .m0_req_i (host_req_i),
    .m0_resp_o(host_resp_o),
    .m1_req_i (eng_req),
    .m1_resp_o(eng_resp),
    .s_req_o  (mem_req),
    .s_resp_i (mem_resp)
  );

  slow_memory #(
    .num_words(`EXT_DEV_MEM_WORDS)
  ) slow_ram_i (
    .clk_i,
    .arst_n_i,
    .req_i (mem_req),
    .resp_o(mem_resp)
  );

  gpio_cnt gpio_cnt_i (
    .clk_i,
    .arst_n_i,
    .gpio_i,
    .gpio_o
  );

  assign memcopy_intr_o = done;

endmodule

//--- logic/gpio_cnt.sv
// Rising edge counter on gpio_i that flips gpio_o every cnt_max edges
// Input goes through two sync flops, so edges count two cycles late

`timescale 1ns/1ns

`include "ext_dev_params.svh"

module gpio_cnt #(
  parameter int cnt_max = `EXT_DEV_CNT_MAX
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic gpio_i,
  output logic gpio_o
);

  localparam int cnt_w = $clog2(cnt_max + 1);

  logic [1:0]       sync_q;
  logic             prev_q;
  logic             rise;
  logic [cnt_w-1:0] cnt_q;
  logic             out_q;

  assign rise = sync_q[1] && !prev_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= '0;
      prev_q <= 1'b0;
      cnt_q  <= '0;
      out_q  <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], gpio_i};
      prev_q <= sync_q[1];
      if (rise) begin
        if (cnt_q == cnt_w'(cnt_max - 1)) begin
          cnt_q <= '0;
          out_q <= !out_q;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  assign gpio_o = out_q;

endmodule

//--- logic/obi_arbiter.sv
// Two masters share one OBI slave and m0 wins when the slave is free
// No new grant until the last granted access has seen its rvalid

`timescale 1ns/1ns

module obi_arbiter
  import ext_dev_pkg::*;
(
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  obi_req_t  m0_req_i,
  output obi_resp_t m0_resp_o,
  input  obi_req_t  m1_req_i,
  output obi_resp_t m1_resp_o,
  output obi_req_t  s_req_o,
  input  obi_resp_t s_resp_i
);

  logic pending_q;
  logic locked_q;
  logic owner_q;
  logic sel;

  // Owner stays selected while its request waits for gnt or its rvalid
  assign sel = (pending_q || locked_q) ? owner_q : !m0_req_i.req;

  always_comb begin
    s_req_o = sel ? m1_req_i : m0_req_i;
    if (pending_q) s_req_o.req = 1'b0;
  end

  assign m0_resp_o.gnt    = s_resp_i.gnt && !sel && !pending_q;
  assign m1_resp_o.gnt    = s_resp_i.gnt && sel && !pending_q;
  assign m0_resp_o.rvalid = s_resp_i.rvalid && pending_q && !owner_q;
  assign m1_resp_o.rvalid = s_resp_i.rvalid && pending_q && owner_q;
  assign m0_resp_o.rdata  = s_resp_i.rdata;
  assign m1_resp_o.rdata  = s_resp_i.rdata;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= 1'b0;
      locked_q  <= 1'b0;
      owner_q   <= 1'b0;
    end else if (pending_q) begin
      if (s_resp_i.rvalid) pending_q <= 1'b0;
    end else if (s_req_o.req) begin
      owner_q   <= sel;
      pending_q <= s_resp_i.gnt;
      locked_q  <= !s_resp_i.gnt;
    end else begin
      locked_q <= 1'b0;
    end
  end

  // Slave must stay quiet while a response is owed
  no_gnt_pending: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pending_q |-> !s_resp_i.gnt);

endmodule

//--- memcopy/memcopy_engine.sv
// Word copy engine on an OBI master port with one access outstanding
// Addresses are word aligned and the low two bits are dropped

`timescale 1ns/1ns

`include "ext_dev_params.svh"

module memcopy_engine
  import ext_dev_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic [31:0]               src_i,
  input  logic [31:0]               dst_i,
  input  logic [`EXT_DEV_LEN_W-1:0] len_i,
  input  logic                      start_i,
  output logic                      busy_o,
  output obi_req_t                  obi_req_o,
  input  obi_resp_t                 obi_resp_i,
  output logic                      done_o
);

  typedef enum logic [2:0] {
    st_idle,
    st_read,
    st_wait_rd,
    st_write,
    st_wait_wr,
    st_done
  } state_t;

  state_t                     state_q;
  state_t                     state_d;
  logic [`EXT_DEV_LEN_W-1:0]  cnt_q;
  logic [31:0]                src_q;
  logic [31:0]                dst_q;
  logic [`EXT_DEV_DATA_W-1:0] data_q;
  logic                       launch;
  logic                       word_done;

  assign launch    = (state_q == st_idle) && start_i;
  assign word_done = (state_q == st_wait_wr) && obi_resp_i.rvalid;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: begin
        if (start_i) state_d = (len_i == '0) ? st_done : st_read;
      end
      st_read: begin
        if (obi_resp_i.gnt) state_d = st_wait_rd;
      end
      st_wait_rd: begin
        if (obi_resp_i.rvalid) state_d = st_write;
      end
      st_write: begin
        if (obi_resp_i.gnt) state_d = st_wait_wr;
      end
      st_wait_wr: begin
        // Last word goes to done, which raises the interrupt
        if (obi_resp_i.rvalid) state_d = (cnt_q == 1) ? st_done : st_read;
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= st_idle;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (launch) begin
        cnt_q <= len_i;
      end else if (word_done) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (launch) begin
      src_q <= {src_i[31:2], 2'b00};
      dst_q <= {dst_i[31:2], 2'b00};
    end else if (word_done) begin
      src_q <= src_q + 32'd4;
      dst_q <= dst_q + 32'd4;
    end
    if ((state_q == st_wait_rd) && obi_resp_i.rvalid) begin
      data_q <= obi_resp_i.rdata;
    end
  end

  always_comb begin
    obi_req_o.req   = (state_q == st_read) || (state_q == st_write);
    obi_req_o.we    = (state_q == st_write);
    obi_req_o.be    = 4'hF;
    obi_req_o.addr  = (state_q == st_write) ? dst_q : src_q;
    obi_req_o.wdata = data_q;
  end

  assign busy_o = (state_q != st_idle);
  assign done_o = (state_q == st_done);

  // Responses reach the engine only while it waits for one
  rvalid_when_waiting: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    obi_resp_i.rvalid |-> (state_q == st_wait_rd) || (state_q == st_wait_wr));

endmodule

//--- memcopy/memcopy_regs.sv
// Memcopy configuration registers on the register bus
// Only addr[7:0] is decoded, so the map repeats every 256 bytes
// Offsets outside the map answer with error

`timescale 1ns/1ns

`include "ext_dev_params.svh"

module memcopy_regs
  import ext_dev_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  reg_req_t                  reg_req_i,
  output reg_rsp_t                  reg_rsp_o,
  input  logic                      busy_i,
  output logic [31:0]               src_o,
  output logic [31:0]               dst_o,
  output logic [`EXT_DEV_LEN_W-1:0] len_o,
  output logic                      start_o
);

  logic [31:0]               src_q;
  logic [31:0]               dst_q;
  logic [`EXT_DEV_LEN_W-1:0] len_q;
  logic [7:0]                offset;
  logic                      hit_src;
  logic                      hit_dst;
  logic                      hit_len;
  logic                      hit_ctrl;
  logic                      wr;
  logic                      start_q;

  function automatic logic [31:0] apply_strobe(input logic [31:0] old_val,
                                               input logic [31:0] new_val,
                                               input logic [3:0]  strb);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[b*8 +: 8] = new_val[b*8 +: 8];
    end
    return res;
  endfunction

  assign offset   = reg_req_i.addr[7:0];
  assign hit_src  = (offset == REG_SRC[7:0]);
  assign hit_dst  = (offset == REG_DST[7:0]);
  assign hit_len  = (offset == REG_LEN[7:0]);
  assign hit_ctrl = (offset == REG_CTRL[7:0]);
  assign wr       = reg_req_i.valid && reg_req_i.write;

  always_comb begin
    reg_rsp_o.ready = reg_req_i.valid;
    reg_rsp_o.error = reg_req_i.valid && !(hit_src || hit_dst || hit_len || hit_ctrl);
    reg_rsp_o.rdata = '0;
    if (hit_src) reg_rsp_o.rdata = src_q;
    if (hit_dst) reg_rsp_o.rdata = dst_q;
    if (hit_len) reg_rsp_o.rdata = 32'(len_q);
    // A pending start already counts as busy
    if (hit_ctrl) reg_rsp_o.rdata = {31'd0, busy_i | start_q};
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      src_q   <= '0;
      dst_q   <= '0;
      len_q   <= '0;
      start_q <= 1'b0;
    end else begin
      if (wr && hit_src) src_q <= apply_strobe(src_q, reg_req_i.wdata, reg_req_i.wstrb);
      if (wr && hit_dst) dst_q <= apply_strobe(dst_q, reg_req_i.wdata, reg_req_i.wstrb);
      if (wr && hit_len && reg_req_i.wstrb[0]) len_q <= reg_req_i.wdata[`EXT_DEV_LEN_W-1:0];
      // Restart while a copy runs is dropped
      start_q <= wr && hit_ctrl && !busy_i && !start_q;
    end
  end

  assign src_o   = src_q;
  assign dst_o   = dst_q;
  assign len_o   = len_q;
  assign start_o = start_q;

  // The engine only ever sees a start while idle
  start_when_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    start_o |-> !busy_i);

endmodule

//--- slow_memory/slow_memory.sv
// Word memory on an OBI slave port that grants 0 to 3 cycles after a request
// Word index is addr[MEM_AW+1:2]; higher address bits are ignored

`timescale 1ns/1ns

`include "ext_dev_params.svh"

module slow_memory
  import ext_dev_pkg::*;
#(
  parameter int num_words = `EXT_DEV_MEM_WORDS
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  input  obi_req_t  req_i,
  output obi_resp_t resp_o
);

  logic [`EXT_DEV_DATA_W-1:0] mem [num_words];
  logic [`EXT_DEV_DATA_W-1:0] rdata_q;
  logic [`EXT_DEV_MEM_AW-1:0] word_idx;
  logic [7:0]                 lfsr_q;
  logic [1:0]                 wait_q;
  logic [1:0]                 delay;
  logic                       waiting_q;
  logic                       rvalid_q;
  logic                       gnt;

  assign word_idx = req_i.addr[`EXT_DEV_MEM_AW+1:2];

  // Fresh request takes its delay straight from the LFSR
  assign delay = waiting_q ? wait_q : lfsr_q[1:0];
  assign gnt   = req_i.req && (delay == 2'd0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lfsr_q    <= 8'hA5;
      waiting_q <= 1'b0;
      wait_q    <= '0;
      rvalid_q  <= 1'b0;
    end else begin
      // Taps 8,6,5,4
      lfsr_q   <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
      rvalid_q <= gnt;
      if (!req_i.req || gnt) begin
        waiting_q <= 1'b0;
      end else if (!waiting_q) begin
        waiting_q <= 1'b1;
        wait_q    <= lfsr_q[1:0] - 2'd1;
      end else begin
        wait_q <= wait_q - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt && req_i.we) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.be[b]) begin
          mem[word_idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
        end
      end
    end
    if (gnt && !req_i.we) begin
      rdata_q <= mem[word_idx];
    end
  end

  assign resp_o.gnt    = gnt;
  assign resp_o.rvalid = rvalid_q;
  assign resp_o.rdata  = rdata_q;

  // The wait counter relies on a request that holds until its grant
  req_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_i.req && !gnt |=> req_i.req && $stable(req_i.addr) && $stable(req_i.we));

endmodule

//--- testbench/tb_ext_dev_top.sv
// Self-checking testbench for ext_dev_top with random stimulus from a fixed seed
// Slow memory contents and the GPIO edge count are modelled here
// Copy source and destination regions never overlap

`timescale 1ns/1ns

`include "ext_dev_params.svh"

module tb_ext_dev_top
  import ext_dev_pkg::*;
();

  localparam int mem_words      = `EXT_DEV_MEM_WORDS;
  localparam int gnt_timeout    = 64;
  localparam int rvalid_timeout = 8;
  localparam int intr_timeout   = 4000;

  logic      clk;
  logic      arst_n;
  reg_req_t  reg_req;
  reg_rsp_t  reg_rsp;
  obi_req_t  host_req;
  obi_resp_t host_resp;
  logic      gpio_in;
  logic      gpio_out;
  logic      memcopy_intr;

  logic [31:0] model_mem [mem_words];
  logic [31:0] rng_state    = 32'h2f73_22f0;
  int          gpio_edges   = 0;
  int          intr_count   = 0;
  int          error_count  = 0;
  int          check_count  = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;

  ext_dev_top UUT (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .reg_req_i     (reg_req),
    .reg_rsp_o     (reg_rsp),
    .host_req_i    (host_req),
    .host_resp_o   (host_resp),
    .gpio_i        (gpio_in),
    .gpio_o        (gpio_out),
    .memcopy_intr_o(memcopy_intr)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Count interrupt pulses mid-cycle
  always @(negedge clk) begin
    if (arst_n && memcopy_intr) begin
      intr_count++;
    end
  end

  function automatic logic [31:0] rand32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'(rand32() % 32'(hi - lo + 1));
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (error_count == errs_before) begin
      $display("Test %0d, %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d, %s: %0d error(s)", tests_run, name, error_count - errs_before);
    end
  endtask

  // One register bus strobe with its response sampled in the same cycle
  task automatic reg_access(input  logic        write,
                            input  logic [31:0] addr,
                            input  logic [31:0] wdata,
                            output logic [31:0] rdata,
                            output logic        error);
    @(posedge clk);
    #1;
    reg_req.valid = 1'b1;
    reg_req.write = write;
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
    reg_req.wstrb = 4'hF;
    @(negedge clk);
    check_eq($sformatf("reg_rsp_o.ready at 0x%0h", addr), 32'(reg_rsp.ready), 32'd1);
    rdata = reg_rsp.rdata;
    error = reg_rsp.error;
    @(posedge clk);
    #1;
    reg_req = '0;
  endtask

  task automatic reg_write(input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] rd;
    logic        err;
    reg_access(1'b1, addr, wdata, rd, err);
    check_eq($sformatf("reg_rsp_o.error at 0x%0h", addr), 32'(err), 32'd0);
  endtask

  // Host OBI access that holds its request until gnt and then waits for rvalid
  task automatic host_access(input  logic        we,
                             input  logic [3:0]  be,
                             input  int          idx,
                             input  logic [31:0] wdata,
                             output logic [31:0] rdata);
    int   waited;
    logic granted;
    rdata = '0;
    @(posedge clk);
    #1;
    host_req.req   = 1'b1;
    host_req.we    = we;
    host_req.be    = be;
    host_req.addr  = 32'(idx) << 2;
    host_req.wdata = wdata;
    waited = 0;
    @(negedge clk);
    while (!host_resp.gnt && waited < gnt_timeout) begin
      @(negedge clk);
      waited++;
    end
    granted = host_resp.gnt;
    @(posedge clk);
    #1;
    host_req = '0;
    if (!granted) begin
      $display("Timeout: host access to word %0d was never granted", idx);
      error_count++;
    end else begin
      waited = 0;
      @(negedge clk);
      while (!host_resp.rvalid && waited < rvalid_timeout) begin
        @(negedge clk);
        waited++;
      end
      if (host_resp.rvalid) begin
        rdata = host_resp.rdata;
      end else begin
        $display("Timeout: no rvalid for host access to word %0d", idx);
        error_count++;
      end
    end
  endtask

  task automatic host_write(input int idx, input logic [3:0] be, input logic [31:0] data);
    logic [31:0] rd;
    host_access(1'b1, be, idx, data, rd);
    model_mem[idx] = merge_bytes(model_mem[idx], data, be);
  endtask

  task automatic host_read_check(input int idx);
    logic [31:0] rd;
    host_access(1'b0, 4'hF, idx, 32'd0, rd);
    check_eq($sformatf("host_resp_o.rdata word %0d", idx), rd, model_mem[idx]);
  endtask

  task automatic preload_memory();
    for (int i = 0; i < mem_words; i++) begin
      host_write(i, 4'hF, rand32());
    end
  endtask

  task automatic start_copy(input int src_idx, input int dst_idx, input int len);
    reg_write(REG_SRC, 32'(src_idx) << 2);
    reg_write(REG_DST, 32'(dst_idx) << 2);
    reg_write(REG_LEN, 32'(len));
    reg_write(REG_CTRL, 32'd1);
  endtask

  task automatic wait_for_intr(input int target);
    int waited;
    waited = 0;
    while (intr_count < target && waited < intr_timeout) begin
      @(negedge clk);
      waited++;
    end
    if (intr_count < target) begin
      $display("Timeout: memcopy_intr_o did not pulse within %0d cycles", intr_timeout);
      error_count++;
    end
  endtask

  // Exactly one pulse, then every destination word equals its source word
  task automatic finish_copy(input int src_idx, input int dst_idx, input int len,
                             input int intr_before, input int settle);
    wait_for_intr(intr_before + 1);
    repeat (settle) @(negedge clk);
    check_eq("memcopy_intr_o pulse count", 32'(intr_count - intr_before), 32'd1);
    for (int i = 0; i < len; i++) begin
      model_mem[dst_idx + i] = model_mem[src_idx + i];
    end
    for (int i = 0; i < len; i++) begin
      host_read_check(dst_idx + i);
    end
  endtask

  task automatic host_write_readback();
    logic [31:0] r;
    int          idx;
    for (int i = 0; i < 60; i++) begin
      r   = rand32();
      idx = rand_range(0, mem_words - 1);
      if (r[0]) begin
        host_write(idx, r[7:4], rand32());
      end else begin
        host_read_check(idx);
      end
    end
  endtask

  task automatic register_readback();
    logic [31:0] src_v;
    logic [31:0] dst_v;
    logic [31:0] len_v;
    logic [31:0] rd;
    logic        err;
    src_v = rand32();
    dst_v = rand32();
    len_v = rand32();
    reg_write(REG_SRC, src_v);
    reg_write(REG_DST, dst_v);
    reg_write(REG_LEN, len_v);
    reg_access(1'b0, REG_SRC, 32'd0, rd, err);
    check_eq("reg_rsp_o.rdata SRC", rd, src_v);
    reg_access(1'b0, REG_DST, 32'd0, rd, err);
    check_eq("reg_rsp_o.rdata DST", rd, dst_v);
    reg_access(1'b0, REG_LEN, 32'd0, rd, err);
    // LEN keeps only the length field
    check_eq("reg_rsp_o.rdata LEN", rd, 32'(len_v[`EXT_DEV_LEN_W-1:0]));
    reg_access(1'b0, 32'h10, 32'd0, rd, err);
    check_eq("reg_rsp_o.error read 0x10", 32'(err), 32'd1);
    reg_access(1'b1, 32'h24, rand32(), rd, err);
    check_eq("reg_rsp_o.error write 0x24", 32'(err), 32'd1);
  endtask

  task automatic block_copy();
    int          len;
    int          src_idx;
    int          dst_idx;
    int          tmp;
    int          intr_before;
    logic [31:0] r;
    len     = rand_range(1, 16);
    src_idx = rand_range(0, 64 - len);
    dst_idx = rand_range(64, mem_words - len);
    r       = rand32();
    if (r[0]) begin
      tmp     = src_idx;
      src_idx = dst_idx;
      dst_idx = tmp;
    end
    for (int i = 0; i < len; i++) begin
      host_write(src_idx + i, 4'hF, rand32());
    end
    intr_before = intr_count;
    start_copy(src_idx, dst_idx, len);
    finish_copy(src_idx, dst_idx, len, intr_before, 40);
  endtask

  // Host works in the upper half while the copy runs in the lower half
  task automatic copy_under_host_traffic();
    int          len;
    int          src_idx;
    int          dst_idx;
    int          idx;
    int          intr_before;
    int          overlapped;
    int          guard;
    logic        busy;
    logic        err;
    logic [31:0] r;
    logic [31:0] rd;
    len     = rand_range(8, 16);
    src_idx = rand_range(0, 32 - len);
    dst_idx = rand_range(32, 64 - len);
    for (int i = 0; i < len; i++) begin
      host_write(src_idx + i, 4'hF, rand32());
    end
    intr_before = intr_count;
    start_copy(src_idx, dst_idx, len);
    busy       = 1'b1;
    overlapped = 0;
    guard      = 0;
    while (busy && guard < 200) begin
      reg_access(1'b0, REG_CTRL, 32'd0, rd, err);
      busy = rd[0];
      if (busy) begin
        r   = rand32();
        idx = rand_range(64, mem_words - 1);
        if (r[0]) begin
          host_write(idx, r[7:4], rand32());
        end else begin
          host_read_check(idx);
        end
        overlapped++;
      end
      guard++;
    end
    if (busy) begin
      $display("Timeout: copy still busy after %0d status reads", guard);
      error_count++;
    end
    if (overlapped == 0) begin
      $display("No host access was issued while the copy was busy");
      error_count++;
    end
    finish_copy(src_idx, dst_idx, len, intr_before, 40);
  endtask

  task automatic busy_and_restart();
    int          len;
    int          src_idx;
    int          dst_idx;
    int          intr_before;
    logic        err;
    logic [31:0] rd;
    len         = rand_range(4, 16);
    src_idx     = rand_range(0, 64 - len);
    dst_idx     = rand_range(64, mem_words - len);
    intr_before = intr_count;
    start_copy(src_idx, dst_idx, len);
    reg_access(1'b0, REG_CTRL, 32'd0, rd, err);
    check_eq("CTRL busy during copy", rd, 32'd1);
    // Restart while busy must be dropped
    reg_write(REG_CTRL, 32'd1);
    finish_copy(src_idx, dst_idx, len, intr_before, 300);
    reg_access(1'b0, REG_CTRL, 32'd0, rd, err);
    check_eq("CTRL busy after interrupt", rd, 32'd0);
  endtask

  task automatic gpio_edge_count();
    int          n;
    int          expected;
    logic [31:0] r;
    for (int t = 0; t < 6; t++) begin
      n = rand_range(12, 48);
      for (int k = 0; k < n; k++) begin
        r = rand32();
        @(posedge clk);
        #1;
        if (r[0] && !gpio_in) begin
          gpio_edges++;
        end
        gpio_in = r[0];
      end
      // Two sync flops plus edge detect, then the toggle
      repeat (6) @(posedge clk);
      @(negedge clk);
      expected = (gpio_edges / `EXT_DEV_CNT_MAX) % 2;
      check_eq("gpio_o", 32'(gpio_out), 32'(expected));
    end
  endtask

  initial begin
    int errs;
    arst_n   = 1'b0;
    reg_req  = '0;
    host_req = '0;
    gpio_in  = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;
    preload_memory();

    errs = error_count;
    host_write_readback();
    report_test("host write and read-back", errs);
    errs = error_count;
    register_readback();
    report_test("register access", errs);
    errs = error_count;
    block_copy();
    report_test("block copy", errs);
    errs = error_count;
    copy_under_host_traffic();
    report_test("host traffic during copy", errs);
    errs = error_count;
    busy_and_restart();
    report_test("busy status and ignored restart", errs);
    errs = error_count;
    gpio_edge_count();
    report_test("GPIO edge counter", errs);

    $display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
